/* lab_pkg.sv */
package lab_pkg;

    // Shift timer width, one strobe every 2**4 enabled cycles.
    localparam int SHIFT_STROBE_W = 4;

    // Scan timer width, one strobe every second cycle.
    localparam int SEG_STROBE_W = 1;

    localparam int PATTERN_W  = 12; // Pattern register and LED count.
    localparam int NUM_DIGITS = 8;  // Hex digits on the display.

    // Detector states for the sequence 1-0-1.
    // The Mealy machine never enters S_101.
    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_1    = 2'd1,
        S_10   = 2'd2,
        S_101  = 2'd3
    } fsm_state_e;

    // What the seven-segment display shows.
    typedef enum logic {
        DISP_COUNTS  = 1'b0,
        DISP_PATTERN = 1'b1
    } disp_src_e;

    // Event counts, laid out as shown on the display.
    // Digits 7..4 hold strobe_count, 3..2 moore_count, 1..0 mealy_count.
    typedef struct packed {
        logic [15:0] strobe_count;
        logic [7:0]  moore_count;
        logic [7:0]  mealy_count;
    } event_counts_t;

endpackage

/* strobe_gen.sv */
module strobe_gen #(
    parameter int w = 4
) (
    input  logic clk,
    input  logic i_arst_n,
    input  logic i_enable,
    output logic o_strobe
);

    logic [w-1:0] cnt;

    // Free-running counter that holds while disabled.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt <= '0;
        end else if (i_enable) begin
            cnt <= cnt + 1'b1; // Wraps after all ones.
        end
    end

    // One pulse per wrap, only on an enabled cycle.
    assign o_strobe = i_enable & (&cnt);

endmodule

/* key_shifter.sv */
module key_shifter (
    input  logic                         clk,
    input  logic                         i_arst_n,
    input  logic                         i_key,
    input  logic                         i_shift,
    output logic [lab_pkg::PATTERN_W-1:0] o_pattern
);

    logic key_meta;
    logic key_sync;

    // Two-flop synchronizer for the asynchronous key.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            key_meta <= 1'b0;
            key_sync <= 1'b0;
        end else begin
            key_meta <= i_key;
            key_sync <= key_meta;
        end
    end

    // Newest bit enters at bit 0.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pattern <= '0;
        end else if (i_shift) begin
            o_pattern <= {o_pattern[lab_pkg::PATTERN_W-2:0], key_sync};
        end
    end

endmodule

/* seq_detect_fsm.sv */
module seq_detect_fsm (
    input  logic clk,
    input  logic i_arst_n,
    input  logic i_step,
    input  logic i_bit,
    output logic o_moore_hit,
    output logic o_mealy_hit
);

    import lab_pkg::*;

    fsm_state_e moore_state;
    fsm_state_e moore_next;
    fsm_state_e mealy_state;
    fsm_state_e mealy_next;

    // Moore machine, overlapping 1-0-1.
    always_comb begin
        moore_next = moore_state;
        case (moore_state)
            S_IDLE:  moore_next = i_bit ? S_1 : S_IDLE;
            S_1:     moore_next = i_bit ? S_1 : S_10;
            S_10:    moore_next = i_bit ? S_101 : S_IDLE;
            S_101:   moore_next = i_bit ? S_1 : S_10; // Overlap with the last 1.
            default: moore_next = S_IDLE;
        endcase
    end

    // Mealy machine, three states.
    always_comb begin
        mealy_next = mealy_state;
        case (mealy_state)
            S_IDLE:  mealy_next = i_bit ? S_1 : S_IDLE;
            S_1:     mealy_next = i_bit ? S_1 : S_10;
            S_10:    mealy_next = i_bit ? S_1 : S_IDLE; // Completing 1 starts a new one.
            default: mealy_next = S_IDLE;
        endcase
    end

    // Both machines advance only on a step.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            moore_state <= S_IDLE;
            mealy_state <= S_IDLE;
        end else if (i_step) begin
            moore_state <= moore_next;
            mealy_state <= mealy_next;
        end
    end

    // Moore output depends on the state alone.
    assign o_moore_hit = (moore_state == S_101);

    // Mealy output flags the completing bit on the step cycle itself.
    assign o_mealy_hit = i_step & i_bit & (mealy_state == S_10);

endmodule

/* event_counters.sv */
module event_counters (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  logic                   i_shift,
    input  logic                   i_moore_hit,
    input  logic                   i_mealy_hit,
    output lab_pkg::event_counts_t o_counts
);

    // All three counters wrap and only move on a shift strobe.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_counts <= '0;
        end else if (i_shift) begin
            o_counts.strobe_count <= o_counts.strobe_count + 1'b1;

            // Moore output here is the state before this strobe.
            if (i_moore_hit) begin
                o_counts.moore_count <= o_counts.moore_count + 1'b1;
            end

            if (i_mealy_hit) begin
                o_counts.mealy_count <= o_counts.mealy_count + 1'b1;
            end
        end
    end

endmodule

/* seven_segment.sv */
module seven_segment (
    input  logic                           clk,
    input  logic                           i_arst_n,
    input  logic                           i_scan,
    input  lab_pkg::disp_src_e             i_src,
    input  lab_pkg::event_counts_t         i_counts,
    input  logic [lab_pkg::PATTERN_W-1:0]  i_pattern,
    input  logic [lab_pkg::NUM_DIGITS-1:0] i_dots,
    output logic [7:0]                     o_abcdefgh,
    output logic [lab_pkg::NUM_DIGITS-1:0] o_digit
);

    import lab_pkg::*;

    logic [NUM_DIGITS*4-1:0]         number;
    logic [$clog2(NUM_DIGITS)-1:0]   index;
    logic [$clog2(NUM_DIGITS)-1:0]   next_index;
    logic [3:0]                      nibble;
    logic [6:0]                      glyph_n;
    logic [NUM_DIGITS-1:0]           anode_n;

    // Counts, or the pattern zero-extended.
    assign number = (i_src == DISP_COUNTS) ? i_counts
                                           : {{(NUM_DIGITS*4-PATTERN_W){1'b0}}, i_pattern};

    assign next_index = index + 1'b1; // Wraps modulo 8.
    assign nibble     = number[next_index*4 +: 4];
    assign anode_n    = ~(NUM_DIGITS'(1) << next_index);

    // Hex glyph, segments a..g, active low.
    always_comb begin
        case (nibble)
            4'h0: glyph_n = ~7'b1111110;
            4'h1: glyph_n = ~7'b0110000;
            4'h2: glyph_n = ~7'b1101101;
            4'h3: glyph_n = ~7'b1111001;
            4'h4: glyph_n = ~7'b0110011;
            4'h5: glyph_n = ~7'b1011011;
            4'h6: glyph_n = ~7'b1011111;
            4'h7: glyph_n = ~7'b1110000;
            4'h8: glyph_n = ~7'b1111111;
            4'h9: glyph_n = ~7'b1111011;
            4'hA: glyph_n = ~7'b1110111;
            4'hB: glyph_n = ~7'b0011111; // Lower case b.
            4'hC: glyph_n = ~7'b1001110;
            4'hD: glyph_n = ~7'b0111101; // Lower case d.
            4'hE: glyph_n = ~7'b1001111;
            default: glyph_n = ~7'b1000111;
        endcase
    end

    // Index starts at 7 so the first scan shows digit 0.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            index      <= '1;
            o_abcdefgh <= '1; // Blank until the first scan.
            o_digit    <= '1;
        end else if (i_scan) begin
            index      <= next_index;
            o_abcdefgh <= {glyph_n, ~i_dots[next_index]};
            o_digit    <= anode_n;
        end
    end

endmodule

/* lab_top.sv */
module lab_top (
    input  logic                           clk,
    input  logic                           i_arst_n,
    input  logic                           i_key,
    input  logic                           i_run,
    input  lab_pkg::disp_src_e             i_disp_src,
    input  logic [lab_pkg::NUM_DIGITS-1:0] i_dots,
    output logic [lab_pkg::PATTERN_W-1:0]  o_led,
    output logic [7:0]                     o_abcdefgh,
    output logic [lab_pkg::NUM_DIGITS-1:0] o_digit
);

    import lab_pkg::*;

    logic                 shift_strobe;
    logic                 scan_strobe;
    logic [PATTERN_W-1:0] pattern;
    logic                 moore_hit;
    logic                 mealy_hit;
    event_counts_t        counts;

    // Shift timer only runs while i_run is high.
    strobe_gen #(.w(SHIFT_STROBE_W)) i_shift_strobe (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_enable (i_run),
        .o_strobe (shift_strobe)
    );

    strobe_gen #(.w(SEG_STROBE_W)) i_scan_strobe (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_enable (1'b1),
        .o_strobe (scan_strobe)
    );

    key_shifter i_key_shifter (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_key     (i_key),
        .i_shift   (shift_strobe),
        .o_pattern (pattern)
    );

    assign o_led = ~pattern; // LEDs are active low.

    // Detectors see bit 0 as it was before the strobe.
    seq_detect_fsm i_seq_detect_fsm (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_step      (shift_strobe),
        .i_bit       (pattern[0]),
        .o_moore_hit (moore_hit),
        .o_mealy_hit (mealy_hit)
    );

    event_counters i_event_counters (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_shift     (shift_strobe),
        .i_moore_hit (moore_hit),
        .i_mealy_hit (mealy_hit),
        .o_counts    (counts)
    );

    seven_segment i_seven_segment (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_scan     (scan_strobe),
        .i_src      (i_disp_src),
        .i_counts   (counts),
        .i_pattern  (pattern),
        .i_dots     (i_dots),
        .o_abcdefgh (o_abcdefgh),
        .o_digit    (o_digit)
    );

endmodule

/* tb_lab_top_assertions.sv */
module tb_lab_top_assertions (
    input logic                           clk,
    input logic                           i_arst_n,
    input logic [lab_pkg::NUM_DIGITS-1:0] o_digit,
    input logic                           shift_strobe,
    input logic [lab_pkg::PATTERN_W-1:0]  pattern,
    input lab_pkg::event_counts_t         counts,
    input logic                           moore_hit,
    input logic                           mealy_hit
);
    timeunit 1ns;
    timeprecision 100ps;

    int error_count = 0; // Failed assertions so far.

    // At most one anode lit at any time.
    digit_one_hot_low: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        ($onehot(~o_digit) || (o_digit == '1))
    ) else begin
        $error("o_digit has more than one anode low");
        error_count++;
    end

    // Pattern register only moves on the edge that ends a strobe cycle.
    pattern_on_strobe: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (pattern != $past(pattern)) |-> $past(shift_strobe)
    ) else begin
        $error("pattern changed without a shift strobe");
        error_count++;
    end

    counts_on_strobe: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (counts != $past(counts)) |-> $past(shift_strobe)
    ) else begin
        $error("counts changed without a shift strobe");
        error_count++;
    end

    // A Mealy hit puts the Moore machine in S_101 next.
    mealy_then_moore: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        mealy_hit |=> moore_hit
    ) else begin
        $error("mealy_hit not followed by moore_hit");
        error_count++;
    end

endmodule

bind lab_top tb_lab_top_assertions i_assertions (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .o_digit      (o_digit),
    .shift_strobe (shift_strobe),
    .pattern      (pattern),
    .counts       (counts),
    .moore_hit    (moore_hit),
    .mealy_hit    (mealy_hit)
);

/* tb_lab_top.sv */
module tb_lab_top;
    timeunit 1ns;
    timeprecision 100ps;

    import lab_pkg::*;

    localparam int SHIFT_PERIOD    = 2 ** SHIFT_STROBE_W;
    localparam int NUM_STROBES     = 75;  // 10 directed, 60 random, 5 after the pause.
    localparam int NUM_DISP_CHECKS = 7;
    localparam int TIMEOUT_CYCLES  = NUM_STROBES * SHIFT_PERIOD + NUM_DISP_CHECKS * 40 + 200;

    // Directed key bits, first bit in the top position.
    localparam logic [9:0] DIRECTED_BITS = 10'b1010110100;

    // Expected state of the lab, advanced once per strobe.
    typedef struct packed {
        logic [PATTERN_W-1:0] pattern;
        logic [2:0]           hist;   // Last three consumed bits, newest in bit 0.
        event_counts_t        counts;
    } model_t;

    logic                  clk;
    logic                  i_arst_n;
    logic                  i_key;
    logic                  i_run;
    disp_src_e             i_disp_src;
    logic [NUM_DIGITS-1:0] i_dots;
    logic [PATTERN_W-1:0]  o_led;
    logic [7:0]            o_abcdefgh;
    logic [NUM_DIGITS-1:0] o_digit;

    model_t                model;
    logic [31:0]           rng;
    int                    cycle_count = 0;

    // Shared between the main sequence and the scan compare process.
    logic                  scan_en = 1'b0;
    logic                  scan_done = 1'b0;
    logic [NUM_DIGITS-1:0] seen;
    logic [31:0]           exp_number;
    logic [31:0]           shown_number;
    logic [NUM_DIGITS-1:0] exp_dots;
    disp_src_e             exp_src;
    string                 scan_name;

    lab_top i_lab_top (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_key      (i_key),
        .i_run      (i_run),
        .i_disp_src (i_disp_src),
        .i_dots     (i_dots),
        .o_led      (o_led),
        .o_abcdefgh (o_abcdefgh),
        .o_digit    (o_digit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // One strobe. The detectors consume the bit the previous strobe shifted in.
    function automatic model_t step_model(input model_t m, input logic key_bit);
        model_t n;
        logic   consumed;
        n        = m;
        consumed = m.pattern[0];
        n.counts.strobe_count = m.counts.strobe_count + 16'd1;
        if (m.hist == 3'b101) begin // Moore machine sits in S_101.
            n.counts.moore_count = m.counts.moore_count + 8'd1;
        end
        if ({m.hist[1:0], consumed} == 3'b101) begin
            n.counts.mealy_count = m.counts.mealy_count + 8'd1;
        end
        n.hist    = {m.hist[1:0], consumed};
        n.pattern = {m.pattern[PATTERN_W-2:0], key_bit};
        return n;
    endfunction

    function automatic logic [31:0] display_number(input model_t m, input disp_src_e src);
        if (src == DISP_COUNTS) begin
            return m.counts;
        end
        return {{(32-PATTERN_W){1'b0}}, m.pattern};
    endfunction

    // Index of the single low anode, or -1.
    function automatic int digit_index(input logic [NUM_DIGITS-1:0] anodes);
        int idx;
        int lit;
        idx = -1;
        lit = 0;
        for (int d = 0; d < NUM_DIGITS; d++) begin
            if (!anodes[d]) begin
                idx = d;
                lit++;
            end
        end
        if (lit != 1) begin
            idx = -1;
        end
        return idx;
    endfunction

    // Active-high abcdefg back to a nibble; bit 4 marks a known glyph.
    function automatic logic [4:0] decode_glyph(input logic [6:0] seg);
        case (seg)
            7'b1111110: return 5'h10;
            7'b0110000: return 5'h11;
            7'b1101101: return 5'h12;
            7'b1111001: return 5'h13;
            7'b0110011: return 5'h14;
            7'b1011011: return 5'h15;
            7'b1011111: return 5'h16;
            7'b1110000: return 5'h17;
            7'b1111111: return 5'h18;
            7'b1111011: return 5'h19;
            7'b1110111: return 5'h1A;
            7'b0011111: return 5'h1B;
            7'b1001110: return 5'h1C;
            7'b0111101: return 5'h1D;
            7'b1001111: return 5'h1E;
            7'b1000111: return 5'h1F;
            default:    return 5'h00;
        endcase
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s expected %0h actual %0h", name, expected, actual);
            stop_run("first mismatch ends the run");
        end
    endtask

    // Called right after a rising edge; returns on the edge that ends the strobe.
    task automatic run_strobe(input logic key_bit);
        i_key <= key_bit;
        i_run <= 1'b1;
        repeat (SHIFT_PERIOD) @(posedge clk);
        model = step_model(model, key_bit);
    endtask

    task automatic run_random_strobes(input int count);
        for (int n = 0; n < count; n++) begin
            rng = lcg_next(rng);
            run_strobe(rng[16]);
        end
        i_run <= 1'b0;
    endtask

    task automatic check_display(input string name);
        logic [PATTERN_W-1:0] exp_led;
        repeat (3) @(posedge clk); // Let a new selection reach the outputs.
        exp_led    = ~model.pattern;
        exp_src    = i_disp_src;
        exp_dots   = i_dots;
        exp_number = display_number(model, i_disp_src);
        scan_name  = name;
        seen       = '0;
        scan_done  = 1'b0;
        scan_en    = 1'b1;
        wait (scan_done);
        check_value({name, " led"}, exp_led, o_led);
        @(posedge clk);
        scan_en = 1'b0;
    endtask

    // Reads one digit per falling edge until all eight were seen.
    always @(negedge clk) begin : compare_scan
        int         idx;
        logic [4:0] glyph;
        logic       dot_lit;
        if (scan_en && !scan_done && (o_digit != '1)) begin
            idx = digit_index(o_digit);
            if (idx < 0) begin
                stop_run("o_digit does not select exactly one digit");
            end
            glyph = decode_glyph(~o_abcdefgh[7:1]);
            if (!glyph[4]) begin
                stop_run("segments show no valid hex glyph");
            end
            dot_lit = ~o_abcdefgh[0];
            check_value($sformatf("%s dot %0d", scan_name, idx), exp_dots[idx], dot_lit);
            shown_number[idx*4 +: 4] = glyph[3:0];
            seen[idx] = 1'b1;
            if (seen == '1) begin
                if (exp_src == DISP_COUNTS) begin
                    check_value({scan_name, " strobe count"}, exp_number[31:16],
                                shown_number[31:16]);
                    check_value({scan_name, " moore count"}, exp_number[15:8],
                                shown_number[15:8]);
                    check_value({scan_name, " mealy count"}, exp_number[7:0],
                                shown_number[7:0]);
                end else begin
                    check_value({scan_name, " pattern"}, exp_number, shown_number);
                end
                scan_done = 1'b1;
            end
        end
    end

    // Cycle limit, and the bound assertions on lab_top.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_run("run exceeded its cycle limit without finishing");
        end else if (i_lab_top.i_assertions.error_count != 0) begin
            stop_run("an assertion on lab_top internals failed");
        end
    end

    initial begin : main_sequence
        i_arst_n   <= 1'b0;
        i_key      <= 1'b0;
        i_run      <= 1'b0;
        i_disp_src <= DISP_COUNTS;
        i_dots     <= '0;
        model       = '0;
        rng         = 32'd98;

        // Reset, then blank outputs before the first scan strobe.
        repeat (5) @(posedge clk);
        i_arst_n <= 1'b1;
        @(negedge clk);
        check_value("reset led", {PATTERN_W{1'b1}}, o_led);
        check_value("reset digit", 8'hFF, o_digit);
        check_value("reset segments", 8'hFF, o_abcdefgh);
        @(posedge clk);

        // Directed overlapping sequence.
        i_dots <= 8'hA5;
        for (int k = 9; k >= 1; k--) begin
            run_strobe(DIRECTED_BITS[k]);
        end
        i_run <= 1'b0;
        check_value("directed moore model", 2, model.counts.moore_count);
        check_value("directed mealy model", 3, model.counts.mealy_count);
        check_display("directed nine");
        run_strobe(DIRECTED_BITS[0]);
        i_run <= 1'b0;
        check_value("directed moore lag", 3, model.counts.moore_count);
        check_display("directed ten");

        // Random key bits.
        i_dots <= 8'h00;
        run_random_strobes(60);
        check_display("random counts");

        // Pattern view with random dots.
        rng = lcg_next(rng);
        i_disp_src <= DISP_PATTERN;
        i_dots     <= rng[23:16];
        check_display("pattern view");

        // Pause keeps everything still.
        i_disp_src <= DISP_COUNTS;
        i_dots     <= 8'h3C;
        check_display("pause start");
        repeat (100) @(posedge clk);
        check_display("pause end");
        run_random_strobes(5);
        check_display("resume");

        if (i_lab_top.i_assertions.error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* flist.f */
lab_pkg.sv
strobe_gen.sv
key_shifter.sv
seq_detect_fsm.sv
event_counters.sv
seven_segment.sv
lab_top.sv
tb_lab_top_assertions.sv
tb_lab_top.sv
